// ==== source/blas_cfg.svh ====
// BLAS engine sizes
`ifndef BLAS_CFG_SVH
`define BLAS_CFG_SVH

// Lane array
`define BLAS_NUM_LANES	4
`define BLAS_VEC_LEN	16		// Words per vector, per lane

// Datapath widths
`define BLAS_DATA_W		16
`define BLAS_ACC_W		32

// Issue tracking
`define BLAS_ISSUE_W	4		// Wraps at 16

// Host port
`define BLAS_ADDR_W		12

`endif

// ==== source/blas_pkg.sv ====
// BLAS engine shared types
`include "blas_cfg.svh"

package blas_pkg;

	localparam int NUM_LANES	= `BLAS_NUM_LANES;
	localparam int VEC_LEN		= `BLAS_VEC_LEN;
	localparam int DATA_W		= `BLAS_DATA_W;
	localparam int ACC_W		= `BLAS_ACC_W;
	localparam int ISSUE_W		= `BLAS_ISSUE_W;
	localparam int ADDR_W		= `BLAS_ADDR_W;
	localparam int LANE_W		= $clog2(NUM_LANES);
	localparam int IDX_W		= $clog2(VEC_LEN);
	localparam int LEN_W		= IDX_W + 1;		// Holds 1 to VEC_LEN

	localparam logic [1:0] RESP_OKAY	= 2'b00;
	localparam logic [1:0] RESP_SLVERR	= 2'b10;

	typedef logic [ISSUE_W-1:0] issue_no_t;

	typedef enum logic {
		OP_DOT	= 1'b0,
		OP_AXPY	= 1'b1
	} op_t;

	typedef struct packed {
		op_t					op;
		logic [LEN_W-1:0]		len;
		logic [DATA_W-1:0]		alpha;
		logic [NUM_LANES-1:0]	lane_mask;
		issue_no_t				issue_no;
	} instr_t;

	////////////////////////////////////////
	// AXI4-Lite channels

	typedef struct packed {
		logic					awvalid;
		logic [ADDR_W-1:0]		awaddr;
		logic					wvalid;
		logic [31:0]			wdata;
		logic [3:0]				wstrb;
		logic					bready;
		logic					arvalid;
		logic [ADDR_W-1:0]		araddr;
		logic					rready;
	} axil_req_t;

	typedef struct packed {
		logic					awready;
		logic					wready;
		logic					bvalid;
		logic [1:0]				bresp;
		logic					arready;
		logic					rvalid;
		logic [31:0]			rdata;
		logic [1:0]				rresp;
	} axil_rsp_t;

	////////////////////////////////////////
	// Lane side

	typedef struct packed {
		logic					wr_en;
		logic [LANE_W-1:0]		lane;
		logic					vec;		// 0 x, 1 y
		logic [IDX_W-1:0]		idx;
		logic [DATA_W-1:0]		wdata;
	} mem_acc_t;

	typedef struct packed {
		logic					term;
		issue_no_t				issue_no;
		logic [DATA_W-1:0]		rdata;
		logic [ACC_W-1:0]		acc;
	} lane_rsp_t;

	typedef struct packed {
		logic					busy;
		issue_no_t				last_commit;
		logic [7:0]				commit_cnt;
	} stat_t;

endpackage

// ==== source/blas_regs.sv ====
// BLAS engine register block
`timescale 1ns/10ps

module blas_regs
	import blas_pkg::*;
(
	input						clock,
	input						rst_n,
	input	axil_req_t			axil_req,
	output	axil_rsp_t			axil_rsp,
	input	lane_rsp_t			lane_rsp [NUM_LANES],
	input						commit,
	input	issue_no_t			commit_no,
	output	logic				issue,
	output	instr_t				instr,
	output	mem_acc_t			mem_acc,
	output						done
);

	logic						wr_fire;
	logic						ar_fire;
	logic						ctrl_wr;
	logic						mem_wr;
	logic						wr_err;
	logic [LEN_W-1:0]			wr_len;
	logic [NUM_LANES-1:0]		wr_mask;

	logic						bvalid;
	logic [1:0]					bresp;
	logic						rvalid;
	logic						rd_live;		// First cycle of rvalid
	logic [ADDR_W-1:0]			rd_addr;
	logic [31:0]				rd_mux;
	logic [31:0]				rdata_q;

	issue_no_t					next_no;
	stat_t						stat;

	////////////////////////////////////////
	// Write decode

	assign wr_fire	= axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign ar_fire	= axil_req.arvalid && !rvalid && !wr_fire;	// Write owns mem_acc

	assign ctrl_wr	= axil_req.awaddr == '0;
	assign mem_wr	= (axil_req.awaddr[ADDR_W-1:9] == 'd1) && (axil_req.awaddr[1:0] == 2'b00);

	assign wr_len	= axil_req.wdata[LEN_W:1];
	assign wr_mask	= axil_req.wdata[8 +: NUM_LANES];

	assign wr_err	= ((ctrl_wr || mem_wr) && stat.busy) ||
		(ctrl_wr && (wr_len == '0 || wr_len > LEN_W'(VEC_LEN) || wr_mask == '0));

	// Same lane/vec/idx serves host write and read
	always_comb begin
		mem_acc.wr_en	= wr_fire && mem_wr && !wr_err && (axil_req.wstrb[1:0] != 2'b00);
		if (wr_fire) begin
			mem_acc.lane	= axil_req.awaddr[7 +: LANE_W];
			mem_acc.vec		= axil_req.awaddr[6];
			mem_acc.idx		= axil_req.awaddr[2 +: IDX_W];
		end else begin
			mem_acc.lane	= axil_req.araddr[7 +: LANE_W];
			mem_acc.vec		= axil_req.araddr[6];
			mem_acc.idx		= axil_req.araddr[2 +: IDX_W];
		end
		mem_acc.wdata	= axil_req.wdata[DATA_W-1:0];
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bvalid	<= 1'b0;
			bresp	<= RESP_OKAY;
			rvalid	<= 1'b0;
			rd_live	<= 1'b0;
			issue	<= 1'b0;
			instr	<= '0;
			next_no	<= '0;
			stat	<= '0;
		end else begin
			issue	<= 1'b0;
			rd_live	<= ar_fire;

			if (wr_fire) begin
				bvalid	<= 1'b1;
				bresp	<= wr_err ? RESP_SLVERR : RESP_OKAY;
			end else if (axil_req.bready) begin
				bvalid	<= 1'b0;
			end

			if (ar_fire) rvalid <= 1'b1;
			else if (axil_req.rready) rvalid <= 1'b0;

			if (wr_fire && ctrl_wr && !wr_err) begin
				issue		<= 1'b1;
				instr		<= '{op: op_t'(axil_req.wdata[0]), len: wr_len,
					alpha: axil_req.wdata[31:16], lane_mask: wr_mask, issue_no: next_no};
				next_no		<= next_no + 1'b1;
				stat.busy	<= 1'b1;
			end

			if (commit) begin	// Never together with an accepted issue
				stat.busy			<= 1'b0;
				stat.last_commit	<= commit_no;
				stat.commit_cnt		<= stat.commit_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Read path

	always_ff @(posedge clock) begin
		if (ar_fire) rd_addr <= axil_req.araddr;
		if (rd_live) rdata_q <= rd_mux;		// Hold while rready stalls
	end

	always_comb begin
		rd_mux = '0;
		if (rd_addr[1:0] == 2'b00) begin
			if (rd_addr[ADDR_W-1:9] == 'd1)
				rd_mux = 32'(lane_rsp[rd_addr[7 +: LANE_W]].rdata);
			else if (rd_addr[ADDR_W-1:4] == 'd1)
				rd_mux = 32'(lane_rsp[rd_addr[2 +: LANE_W]].acc);
			else if (rd_addr[ADDR_W-1:2] == 'd0)
				rd_mux = 32'(instr.issue_no);
			else if (rd_addr[ADDR_W-1:2] == 'd1)
				rd_mux = {16'b0, stat.commit_cnt, stat.last_commit, 3'b0, stat.busy};
		end
	end

	assign axil_rsp = '{
		awready:	wr_fire,
		wready:		wr_fire,
		bvalid:		bvalid,
		bresp:		bresp,
		arready:	ar_fire,
		rvalid:		rvalid,
		rdata:		rd_live ? rd_mux : rdata_q,
		rresp:		RESP_OKAY
	};

	assign done = commit;

endmodule

// ==== source/lane_unit.sv ====
// BLAS processing lane
`timescale 1ns/10ps

module lane_unit
	import blas_pkg::*;
#(
	parameter int LANE_ID = 0
)
(
	input						clock,
	input						rst_n,
	input						issue,
	input	instr_t				instr,
	input	mem_acc_t			mem_acc,
	output	lane_rsp_t			rsp
);

	logic [DATA_W-1:0]			x_mem [VEC_LEN];
	logic [DATA_W-1:0]			y_mem [VEC_LEN];

	logic						start;
	logic						host_wr;
	logic						run;
	logic						last;
	logic						term;
	logic [IDX_W-1:0]			cnt;
	op_t						op_q;
	logic [LEN_W-1:0]			len_q;
	logic [DATA_W-1:0]			alpha_q;
	issue_no_t					no_q;
	logic [ACC_W-1:0]			acc;
	logic [DATA_W-1:0]			rdata;

	logic [DATA_W-1:0]			x_el;
	logic [DATA_W-1:0]			y_el;
	logic [2*DATA_W-1:0]		prod;
	logic [DATA_W-1:0]			axpy_el;

	assign start	= issue && instr.lane_mask[LANE_ID];
	assign host_wr	= mem_acc.wr_en && (mem_acc.lane == LANE_W'(LANE_ID));
	assign last		= {1'b0, cnt} == len_q - 1'b1;

	// One element per cycle
	assign x_el		= x_mem[cnt];
	assign y_el		= y_mem[cnt];
	assign prod		= {{DATA_W{1'b0}}, x_el} * {{DATA_W{1'b0}}, y_el};
	assign axpy_el	= alpha_q * x_el + y_el;	// Low 16 bits kept

	////////////////////////////////////////
	// Local memories

	always_ff @(posedge clock) begin
		if (host_wr && !mem_acc.vec) x_mem[mem_acc.idx] <= mem_acc.wdata;

		if (host_wr && mem_acc.vec) y_mem[mem_acc.idx] <= mem_acc.wdata;
		else if (run && op_q == OP_AXPY) y_mem[cnt] <= axpy_el;

		rdata <= mem_acc.vec ? y_mem[mem_acc.idx] : x_mem[mem_acc.idx];
	end

	////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run		<= 1'b0;
			term	<= 1'b0;
		end else begin
			term	<= 1'b0;
			if (start) begin
				run		<= 1'b1;
			end else if (run && last) begin
				run		<= 1'b0;
				term	<= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			cnt		<= '0;
			op_q	<= instr.op;
			len_q	<= instr.len;
			alpha_q	<= instr.alpha;
			no_q	<= instr.issue_no;
			if (instr.op == OP_DOT) acc <= '0;
		end else if (run) begin
			cnt		<= cnt + 1'b1;
			if (op_q == OP_DOT) acc <= acc + ACC_W'(prod);	// Mod 2^32
		end
	end

	assign rsp = '{term: term, issue_no: no_q, rdata: rdata, acc: acc};

endmodule

// ==== source/commit_agg.sv ====
// Commit aggregator
`timescale 1ns/10ps

module commit_agg
	import blas_pkg::*;
(
	input						clock,
	input						rst_n,
	input						issue,
	input	instr_t				instr,
	input	lane_rsp_t			lane_rsp [NUM_LANES],
	output	logic				commit,
	output	issue_no_t			commit_no
);

	logic [NUM_LANES-1:0]		pending;
	logic [NUM_LANES-1:0]		hit;
	logic [NUM_LANES-1:0]		remain;

	// Stale issue numbers drop out here
	always_comb begin
		for (int i = 0; i < NUM_LANES; ++i) begin
			hit[i] = lane_rsp[i].term && (lane_rsp[i].issue_no == commit_no);
		end
	end

	assign remain = pending & ~hit;

	////////////////////////////////////////
	// Pending set

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pending		<= '0;
			commit		<= 1'b0;
			commit_no	<= '0;
		end else begin
			commit		<= 1'b0;
			if (issue) begin
				pending		<= instr.lane_mask;		// Never empty on issue
				commit_no	<= instr.issue_no;
			end else if (pending != '0) begin
				pending		<= remain;
				if (remain == '0) commit <= 1'b1;	// Last lane in
			end
		end
	end

endmodule

// ==== source/blas_engine.sv ====
// BLAS engine top level
`timescale 1ns/10ps

module blas_engine
	import blas_pkg::*;
(
	input						clock,
	input						rst_n,
	input	axil_req_t			axil_req,
	output	axil_rsp_t			axil_rsp,
	output						done
);

	logic						issue;
	instr_t						instr;
	mem_acc_t					mem_acc;
	lane_rsp_t					lane_rsp [NUM_LANES];

	logic						commit;
	issue_no_t					commit_no;

	blas_regs blas_regs (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.axil_req(		axil_req		),
		.axil_rsp(		axil_rsp		),
		.lane_rsp(		lane_rsp		),
		.commit(		commit			),
		.commit_no(		commit_no		),
		.issue(			issue			),
		.instr(			instr			),
		.mem_acc(		mem_acc			),
		.done(			done			)
	);

	// Instruction broadcast to every lane
	for (genvar i = 0; i < NUM_LANES; ++i) begin : g_lane
		lane_unit #(
			.LANE_ID(		i				)
		) lane_unit (
			.clock(			clock			),
			.rst_n(			rst_n			),
			.issue(			issue			),
			.instr(			instr			),
			.mem_acc(		mem_acc			),
			.rsp(			lane_rsp[i]		)
		);
	end

	commit_agg commit_agg (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.issue(			issue			),
		.instr(			instr			),
		.lane_rsp(		lane_rsp		),
		.commit(		commit			),
		.commit_no(		commit_no		)
	);

endmodule

// ==== dv/tb_clk.sv ====
// Testbench clock source
`timescale 1ns/10ps

module tb_clk #(
	parameter real PERIOD = 8.0
)
(
	output logic	clock
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

endmodule

// ==== dv/blas_engine_assert.sv ====
// BLAS engine protocol checks
`timescale 1ns/10ps

module blas_engine_assert
	import blas_pkg::*;
(
	input					clock,
	input					rst_n,
	input	axil_req_t		axil_req,
	input	axil_rsp_t		axil_rsp,
	input					done,
	input					issue,
	input					busy
);

	int						fail_cnt = 0;
	logic					in_flight;		// Between an issue and its done

	always_ff @(posedge clock) begin
		if (!rst_n) in_flight <= 1'b0;
		else if (issue) in_flight <= 1'b1;
		else if (done) in_flight <= 1'b0;
	end

	////////////////////////////////////////
	// AXI4-Lite response channels

	bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_cnt++;
		end

	rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_cnt++;
		end

	////////////////////////////////////////
	// Issue and commit

	done_single: assert property (@(posedge clock) disable iff (!rst_n)
		done |=> !done)
		else begin
			$error("done high in two consecutive cycles");
			fail_cnt++;
		end

	busy_fall: assert property (@(posedge clock) disable iff (!rst_n)
		$fell(busy) |-> $past(done))
		else begin
			$error("busy fell without a commit");
			fail_cnt++;
		end

	issue_idle: assert property (@(posedge clock) disable iff (!rst_n)
		issue |-> !in_flight)
		else begin
			$error("instruction issued while busy");
			fail_cnt++;
		end

endmodule

bind blas_engine blas_engine_assert blas_engine_assert_i (
	.clock(		clock					),
	.rst_n(		rst_n					),
	.axil_req(	axil_req				),
	.axil_rsp(	axil_rsp				),
	.done(		done					),
	.issue(		issue					),
	.busy(		blas_regs.stat.busy		)
);

// ==== dv/blas_engine_tb.sv ====
// BLAS engine testbench
`timescale 1ns/10ps
`include "blas_cfg.svh"

module blas_engine_tb
	import blas_pkg::*;
();

	localparam int LANES	= `BLAS_NUM_LANES;
	localparam int VLEN		= `BLAS_VEC_LEN;
	localparam int TIMEOUT	= 4000;		// Tests take about 1700 cycles
	localparam logic [1:0] OKAY		= 2'b00;
	localparam logic [1:0] SLVERR	= 2'b10;

	logic			clock;
	logic			rst_n;
	axil_req_t		req;
	axil_rsp_t		rsp;
	logic			done;

	// Reference model of the lanes
	logic [15:0]	x_m [LANES][VLEN];
	logic [15:0]	y_m [LANES][VLEN];
	logic [31:0]	acc_m [LANES];
	logic [3:0]		issue_m;		// Next issue number
	logic [3:0]		last_no;

	int				issued = 0;
	int				done_cnt = 0;
	int				cycles = 0;
	int				errors = 0;
	int				chk_fails = 0;	// Bound checker failures already counted
	int				n_pass = 0;
	int				n_fail = 0;
	int				seed;

	tb_clk tb_clk_i (.clock(clock));

	blas_engine dut_i (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.axil_req(	req			),
		.axil_rsp(	rsp			),
		.done(		done		)
	);

	always @(negedge clock) begin
		if (rst_n && done) done_cnt++;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped by timeout after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// AXI4-Lite master

	task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clock);
		#1;
		req.awvalid	= 1'b1;
		req.awaddr	= addr;
		req.wvalid	= 1'b1;
		req.wdata	= data;
		req.wstrb	= 4'hf;
		@(negedge clock);
		while (!rsp.awready) @(negedge clock);
		expect_eq("wready", 32'(rsp.wready), 32'h1);
		@(posedge clock);
		#1;
		req.awvalid	= 1'b0;
		req.wvalid	= 1'b0;
		@(negedge clock);
		while (!rsp.bvalid) @(negedge clock);
		resp = rsp.bresp;
		@(posedge clock);		// One cycle of back-pressure
		#1;
		req.bready	= 1'b1;
		@(posedge clock);
		#1;
		req.bready	= 1'b0;
	endtask

	task automatic read_word(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clock);
		#1;
		req.arvalid	= 1'b1;
		req.araddr	= addr;
		@(negedge clock);
		while (!rsp.arready) @(negedge clock);
		@(posedge clock);
		#1;
		req.arvalid	= 1'b0;
		@(negedge clock);
		while (!rsp.rvalid) @(negedge clock);
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clock);
		#1;
		req.rready	= 1'b1;
		@(posedge clock);
		#1;
		req.rready	= 1'b0;
	endtask

	////////////////////////////////////////
	// Checks and model

	task automatic expect_eq(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
		input logic [1:0] exp, input string what);
		logic [1:0] resp;
		write_word(addr, data, resp);
		expect_eq(what, 32'(resp), 32'(exp));
	endtask

	task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] data;
		logic [1:0] resp;
		read_word(addr, data, resp);
		expect_eq(what, data, exp);
		expect_eq({what, " resp"}, 32'(resp), 32'(OKAY));
	endtask

	function automatic logic [11:0] mem_addr(input int lane, input int vec, input int idx);
		return 12'h200 | 12'(lane << 7) | 12'(vec << 6) | 12'(idx << 2);
	endfunction

	function automatic logic [31:0] ctrl_word(input logic op, input int len,
		input logic [3:0] mask, input logic [15:0] alpha);
		return {alpha, 4'b0, mask, 2'b0, 5'(len), op};
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic [3:0] last,
		input int cnt);
		return {16'h0, 8'(cnt), last, 3'b0, busy};
	endfunction

	task automatic start_instr(input logic op, input int len, input logic [3:0] mask,
		input logic [15:0] alpha);
		write_expect(12'h000, ctrl_word(op, len, mask, alpha), OKAY, "CTRL write");
		issued++;
		last_no = issue_m;
		issue_m++;
		for (int l = 0; l < LANES; l++) begin
			if (mask[l]) begin
				if (!op) acc_m[l] = '0;
				for (int i = 0; i < len; i++) begin
					if (!op) acc_m[l] = acc_m[l] + 32'(x_m[l][i]) * 32'(y_m[l][i]);
					else y_m[l][i] = alpha * x_m[l][i] + y_m[l][i];		// Low 16 bits
				end
			end
		end
	endtask

	task automatic wait_commits(input int n);
		while (done_cnt < n) @(posedge clock);
	endtask

	task automatic check_accs();
		for (int l = 0; l < LANES; l++)
			read_expect(12'h010 + 12'(4 * l), acc_m[l], $sformatf("lane %0d acc", l));
	endtask

	task automatic check_mems(input int first_vec);
		for (int l = 0; l < LANES; l++) begin
			for (int v = first_vec; v < 2; v++) begin
				for (int i = 0; i < VLEN; i++) begin
					read_expect(mem_addr(l, v, i), 32'(v ? y_m[l][i] : x_m[l][i]),
						$sformatf("lane %0d %s[%0d]", l, v ? "y" : "x", i));
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		int fails;
		fails = errors + dut_i.blas_engine_assert_i.fail_cnt - chk_fails;
		chk_fails = dut_i.blas_engine_assert_i.fail_cnt;
		if (fails == 0) begin
			n_pass++;
			$display("%s: ok", name);
		end else begin
			n_fail++;
			$display("%s: %0d errors", name, fails);
		end
		errors = 0;
	endtask

	////////////////////////////////////////
	// Tests

	initial begin
		logic [31:0]	data;
		logic [15:0]	alpha;
		req		= '0;
		rst_n	= 1'b0;
		seed	= 32'h709a3195;
		issue_m	= '0;
		last_no	= '0;
		repeat (4) @(posedge clock);
		#1;
		rst_n	= 1'b1;

		read_expect(12'h004, 32'h0, "STATUS");
		read_expect(12'h000, 32'h0, "CTRL issue number");
		finish_test("test 1 reset state");

		for (int l = 0; l < LANES; l++) begin
			for (int v = 0; v < 2; v++) begin
				for (int i = 0; i < VLEN; i++) begin
					data = $random(seed);
					write_expect(mem_addr(l, v, i), data, OKAY, "memory write");
					if (v == 0) x_m[l][i] = data[15:0];
					else y_m[l][i] = data[15:0];
				end
			end
		end
		check_mems(0);
		finish_test("test 2 memory access");

		start_instr(1'b0, 16, 4'b1111, 16'h0);
		wait_commits(issued);
		check_accs();
		read_expect(12'h004, status_word(1'b0, last_no, issued), "STATUS");
		finish_test("test 3 dot product");

		alpha = 16'($random(seed));
		start_instr(1'b1, 9, 4'b0101, alpha);
		wait_commits(issued);
		check_mems(1);			// y of every lane
		check_accs();
		finish_test("test 4 axpy");

		start_instr(1'b0, 16, 4'b1111, 16'h0);
		write_expect(12'h000, ctrl_word(1'b1, 4, 4'b0011, 16'h1), SLVERR, "CTRL write busy");
		write_expect(mem_addr(1, 0, 3), 32'h0000_beef, SLVERR, "memory write busy");
		wait_commits(issued);
		repeat (24) @(posedge clock);	// Longer than any instruction
		expect_eq("done pulses", done_cnt, issued);
		read_expect(mem_addr(1, 0, 3), 32'(x_m[1][3]), "lane 1 x[3]");
		check_accs();
		finish_test("test 5 writes while busy");

		write_expect(12'h000, ctrl_word(1'b0, 4, 4'b0000, 16'h0), SLVERR, "CTRL mask 0");
		write_expect(12'h000, ctrl_word(1'b0, 0, 4'b1111, 16'h0), SLVERR, "CTRL len 0");
		repeat (8) @(posedge clock);
		expect_eq("done pulses", done_cnt, issued);
		read_expect(12'h000, 32'(last_no), "CTRL issue number");
		for (int n = 0; n < 14; n++) begin		// Runs past the wrap
			start_instr(1'b0, 1, 4'b0001, 16'h0);
			wait_commits(issued);
			read_expect(12'h000, 32'(last_no), "CTRL issue number");
		end
		read_expect(12'h004, status_word(1'b0, last_no, issued), "STATUS");
		check_accs();
		finish_test("test 6 rejects and wrap");

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== blas_lite.f ====
+incdir+source
source/blas_pkg.sv
source/blas_regs.sv
source/lane_unit.sv
source/commit_agg.sv
source/blas_engine.sv
dv/tb_clk.sv
dv/blas_engine_assert.sv
dv/blas_engine_tb.sv

// ==== Makefile ====
# Verilator build and run for the BLAS engine

VERILATOR	?= verilator
TOP			?= blas_engine_tb
LINT_TOP	?= blas_engine
FILELIST	?= blas_lite.f
BUILD_DIR	?= obj_dir
LOG			?= sim.log
TIMESCALE	?= 1ns/10ps
VFLAGS		?= --binary --assert -Wno-fatal
LINT_FLAGS	?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timing --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
